// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
    input  aluOpType             op,
    input  logic [wordWidth-1:0] leftOperand,
    input  logic [wordWidth-1:0] rightOperand,
    output logic [wordWidth-1:0] result,
    output logic                 zero
);
    logic lessThan;

    // signed compare
    assign lessThan = $signed(leftOperand) < $signed(rightOperand);

    always_comb begin
        case (op)
            aluAdd: begin
                result = leftOperand + rightOperand;
            end
            aluSub: begin
                result = leftOperand - rightOperand;
            end
            aluAnd: begin
                result = leftOperand & rightOperand;
            end
            aluOr: begin
                result = leftOperand | rightOperand;
            end
            aluSlt: begin
                result = {{(wordWidth - 1){1'b0}}, lessThan};
            end
            // shift amount arrives on the left operand
            aluSll: begin
                result = rightOperand << leftOperand[4:0];
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int wordWidth = 32;
    localparam int regIndexWidth = 5;

    // $ra, written by jal
    localparam logic [regIndexWidth-1:0] linkRegister = 5'd31;

    localparam int dataRamWords = 64;
    localparam int dataRamIndexWidth = 6;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4,
        aluSll = 3'd5
    } aluOpType;

endpackage

`default_nettype wire

// File: hw/ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf import cpuPkg::*; (
    input logic clk,
    input logic rstN
);
    logic regDst;
    logic jump;
    logic jumpAndLink;
    logic jumpRegister;
    logic branchEq;
    logic branchNe;
    logic memWrite;
    logic memToReg;
    logic aluSrcImm;
    logic aluSrcShamt;
    logic regWrite;
    aluOpType aluOp;

    // clock and reset only sample the decoder checks
    modport decoder (
        input clk, rstN,
        output regDst, jump, jumpAndLink, jumpRegister, branchEq, branchNe,
        output memWrite, memToReg, aluSrcImm, aluSrcShamt, regWrite, aluOp
    );

    modport datapath (
        input regDst, jump, jumpAndLink, jumpRegister, branchEq, branchNe,
        input memWrite, memToReg, aluSrcImm, aluSrcShamt, regWrite, aluOp
    );
endinterface

`default_nettype wire

// File: hw/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

module dataRam import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 writeEnable,
    input  logic [wordWidth-1:0] address,
    input  logic [wordWidth-1:0] writeData,
    output logic [wordWidth-1:0] readData
);
    logic [wordWidth-1:0] mem [dataRamWords];
    logic [dataRamIndexWidth-1:0] wordIndex;

    // word addressed, byte offset dropped
    assign wordIndex = address[dataRamIndexWidth+1:2];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < dataRamWords; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEnable) begin
            mem[wordIndex] <= writeData;
        end
    end

    assign readData = mem[wordIndex];

    alignedStore: assert property (
        @(posedge clk) disable iff (!rstN)
        writeEnable |-> address[1:0] == 2'b00
    ) else $error("unaligned store to address %h", address);

endmodule

`default_nettype wire

// File: hw/isaPkg.sv
`default_nettype none

package isaPkg;

    // primary opcode field
    typedef enum logic [5:0] {
        rType = 6'h00,
        j     = 6'h02,
        jal   = 6'h03,
        beq   = 6'h04,
        bne   = 6'h05,
        addi  = 6'h08,
        lw    = 6'h23,
        sw    = 6'h2b
    } opcodeType;

    // funct field, only meaningful for rType
    typedef enum logic [5:0] {
        sll   = 6'h00,
        jr    = 6'h08,
        add   = 6'h20,
        sub   = 6'h22,
        andOp = 6'h24,
        orOp  = 6'h25,
        slt   = 6'h2a
    } functType;

    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 26;
    localparam int rsMsb = 25;
    localparam int rsLsb = 21;
    localparam int rtMsb = 20;
    localparam int rtLsb = 16;
    localparam int rdMsb = 15;
    localparam int rdLsb = 11;
    localparam int shamtMsb = 10;
    localparam int shamtLsb = 6;
    localparam int functMsb = 5;
    localparam int functLsb = 0;
    localparam int immMsb = 15;
    localparam int immLsb = 0;
    localparam int targetMsb = 25;
    localparam int targetLsb = 0;

    localparam int shamtWidth = shamtMsb - shamtLsb + 1;
    localparam int immWidth = immMsb - immLsb + 1;
    localparam int targetWidth = targetMsb - targetLsb + 1;

endpackage

`default_nettype wire

// File: hw/opcodeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder import cpuPkg::*; import isaPkg::*; (
    input  logic [wordWidth-1:0] instruction,
    ctrlIf.decoder               ctrl
);
    opcodeType opcode;
    functType funct;

    assign opcode = opcodeType'(instruction[opcodeMsb:opcodeLsb]);
    assign funct = functType'(instruction[functMsb:functLsb]);

    always_comb begin
        // defaults describe a nop
        ctrl.regDst = 1'b0;
        ctrl.jump = 1'b0;
        ctrl.jumpAndLink = 1'b0;
        ctrl.jumpRegister = 1'b0;
        ctrl.branchEq = 1'b0;
        ctrl.branchNe = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.aluSrcShamt = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.aluOp = aluAdd;

        case (opcode)
            rType: begin
                ctrl.regDst = 1'b1;
                case (funct)
                    add: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluAdd;
                    end
                    sub: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluSub;
                    end
                    andOp: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluAnd;
                    end
                    orOp: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluOr;
                    end
                    slt: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluSlt;
                    end
                    sll: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluSrcShamt = 1'b1;
                        ctrl.aluOp = aluSll;
                    end
                    jr: ctrl.jumpRegister = 1'b1;
                    default: ;
                endcase
            end
            addi: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            lw: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            sw: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            // equality comes from the zero flag after a subtract
            beq: begin
                ctrl.branchEq = 1'b1;
                ctrl.aluOp = aluSub;
            end
            bne: begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp = aluSub;
            end
            j: ctrl.jump = 1'b1;
            jal: begin
                ctrl.jump = 1'b1;
                ctrl.jumpAndLink = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

    // next-pc sources are mutually exclusive
    redirectExclusive: assert property (
        @(posedge ctrl.clk) disable iff (!ctrl.rstN)
        $onehot0({ctrl.jump, ctrl.jumpRegister, ctrl.branchEq, ctrl.branchNe})
    ) else $error("more than one pc redirect decoded");

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [regIndexWidth-1:0] readIndexA,
    input  logic [regIndexWidth-1:0] readIndexB,
    input  logic [regIndexWidth-1:0] writeIndex,
    input  logic                     writeEnable,
    input  logic [wordWidth-1:0]     writeData,
    output logic [wordWidth-1:0]     readDataA,
    output logic [wordWidth-1:0]     readDataB
);
    logic [wordWidth-1:0] regs [2**regIndexWidth];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regIndexWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeIndex != '0) begin
            regs[writeIndex] <= writeData;
        end
    end

    // $zero is hardwired
    assign readDataA = (readIndexA == '0) ? '0 : regs[readIndexA];
    assign readDataB = (readIndexB == '0) ? '0 : regs[readIndexB];

    zeroRegStable: assert property (
        @(posedge clk) disable iff (!rstN)
        1'b1 |=> regs[0] == '0
    ) else $error("register 0 holds a nonzero value");

endmodule

`default_nettype wire

// File: hw/singleCycleCpu.sv
`timescale 1ns/1ps
`default_nettype none

module singleCycleCpu import cpuPkg::*; import isaPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [wordWidth-1:0]     instruction,
    output logic [wordWidth-1:0]     pcOut,
    output logic                     wbEnable,
    output logic [regIndexWidth-1:0] wbRegister,
    output logic [wordWidth-1:0]     wbData,
    output logic                     storeEnable,
    output logic [wordWidth-1:0]     storeAddress,
    output logic [wordWidth-1:0]     storeData
);
    logic [wordWidth-1:0] pcPlusFour;
    logic [wordWidth-1:0] nextPc;
    logic [wordWidth-1:0] branchTarget;
    logic [wordWidth-1:0] jumpTarget;
    logic [wordWidth-1:0] extendedImmediate;
    logic [wordWidth-1:0] rsData;
    logic [wordWidth-1:0] rtData;
    logic [wordWidth-1:0] aluSourceA;
    logic [wordWidth-1:0] aluSourceB;
    logic [wordWidth-1:0] aluResult;
    logic                 aluZero;
    logic                 branchTaken;
    logic [wordWidth-1:0] memReadData;
    logic [regIndexWidth-1:0] destRegister;
    logic [wordWidth-1:0] writebackData;

    ctrlIf ctrl0 (
        .clk  (clk),
        .rstN (rstN)
    );

    opcodeDecoder decoder0 (
        .instruction (instruction),
        .ctrl        (ctrl0.decoder)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcOut <= '0;
        end else begin
            pcOut <= nextPc;
        end
    end

    assign pcPlusFour = pcOut + 32'd4;
    assign extendedImmediate = {
        {(wordWidth - immWidth){instruction[immMsb]}},
        instruction[immMsb:immLsb]
    };

    regFile registers0 (
        .clk         (clk),
        .rstN        (rstN),
        .readIndexA  (instruction[rsMsb:rsLsb]),
        .readIndexB  (instruction[rtMsb:rtLsb]),
        .writeIndex  (destRegister),
        .writeEnable (wbEnable),
        .writeData   (writebackData),
        .readDataA   (rsData),
        .readDataB   (rtData)
    );

    // sll takes its shift amount from the shamt field
    assign aluSourceA = ctrl0.aluSrcShamt
        ? {{(wordWidth - shamtWidth){1'b0}}, instruction[shamtMsb:shamtLsb]}
        : rsData;
    assign aluSourceB = ctrl0.aluSrcImm ? extendedImmediate : rtData;

    alu alu0 (
        .op           (ctrl0.aluOp),
        .leftOperand  (aluSourceA),
        .rightOperand (aluSourceB),
        .result       (aluResult),
        .zero         (aluZero)
    );

    dataRam dataRam0 (
        .clk         (clk),
        .rstN        (rstN),
        .writeEnable (storeEnable),
        .address     (storeAddress),
        .writeData   (storeData),
        .readData    (memReadData)
    );

    // next pc
    assign branchTaken = (ctrl0.branchEq && aluZero) || (ctrl0.branchNe && !aluZero);
    assign branchTarget = pcPlusFour + {extendedImmediate[wordWidth-3:0], 2'b00};
    assign jumpTarget = {
        pcPlusFour[wordWidth-1:targetWidth+2],
        instruction[targetMsb:targetLsb],
        2'b00
    };

    always_comb begin
        if (ctrl0.jumpRegister) begin
            nextPc = rsData;
        end else if (ctrl0.jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlusFour;
        end
    end

    // writeback selection
    always_comb begin
        if (ctrl0.jumpAndLink) begin
            destRegister = linkRegister;
        end else if (ctrl0.regDst) begin
            destRegister = instruction[rdMsb:rdLsb];
        end else begin
            destRegister = instruction[rtMsb:rtLsb];
        end
    end

    always_comb begin
        if (ctrl0.jumpAndLink) begin
            writebackData = pcPlusFour;
        end else if (ctrl0.memToReg) begin
            writebackData = memReadData;
        end else begin
            writebackData = aluResult;
        end
    end

    // retire trace, same nets that feed the register file and RAM
    assign wbEnable = ctrl0.regWrite && (destRegister != '0);
    assign wbRegister = destRegister;
    assign wbData = writebackData;
    assign storeEnable = ctrl0.memWrite;
    assign storeAddress = aluResult;
    assign storeData = rtData;

endmodule

`default_nettype wire

// File: singleCycleCpu.f
hw/cpuPkg.sv
hw/isaPkg.sv
hw/ctrlIf.sv
hw/opcodeDecoder.sv
hw/regFile.sv
hw/alu.sv
hw/dataRam.sv
hw/singleCycleCpu.sv
tb/clockGen.sv
tb/cpuChecker.sv
tb/singleCycleCpuTb.sv

// File: tb/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstN
);
    localparam int halfPeriod = 50;
    localparam int resetCycles = 4;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // release lands on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/cpuChecker.sv
`timescale 1ns/1ps
`default_nettype none

module cpuChecker import cpuPkg::*; (
    input  logic                     clk,
    input  logic                     checkEnable,
    input  int                       rowNumber,
    input  logic [wordWidth-1:0]     expectedPc,
    input  logic                     expectedWbEnable,
    input  logic [regIndexWidth-1:0] expectedWbRegister,
    input  logic [wordWidth-1:0]     expectedWbData,
    input  logic                     expectedStoreEnable,
    input  logic [wordWidth-1:0]     expectedStoreAddress,
    input  logic [wordWidth-1:0]     expectedStoreData,
    input  logic [wordWidth-1:0]     pcOut,
    input  logic                     wbEnable,
    input  logic [regIndexWidth-1:0] wbRegister,
    input  logic [wordWidth-1:0]     wbData,
    input  logic                     storeEnable,
    input  logic [wordWidth-1:0]     storeAddress,
    input  logic [wordWidth-1:0]     storeData,
    output int                       checkCount,
    output int                       errorCount
);
    // 10 ns ahead of the rising edge that commits the row
    localparam int sampleDelay = 40;

    bit rowOk;

    function automatic bit fieldMatches(
        input int                   row,
        input string                name,
        input logic [wordWidth-1:0] expected,
        input logic [wordWidth-1:0] actual
    );
        if (actual !== expected) begin
            $display("Mismatch row %0d: %s expected %h got %h", row, name, expected, actual);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    initial begin
        checkCount = 0;
        errorCount = 0;
    end

    always @(negedge clk) begin
        #sampleDelay;
        if (checkEnable) begin
            rowOk = fieldMatches(rowNumber, "pcOut", expectedPc, pcOut);
            rowOk &= fieldMatches(rowNumber, "wbEnable", expectedWbEnable, wbEnable);
            rowOk &= fieldMatches(rowNumber, "storeEnable", expectedStoreEnable, storeEnable);
            // payload only means something while its enable is high
            if (expectedWbEnable) begin
                rowOk &= fieldMatches(rowNumber, "wbRegister", expectedWbRegister, wbRegister);
                rowOk &= fieldMatches(rowNumber, "wbData", expectedWbData, wbData);
            end
            if (expectedStoreEnable) begin
                rowOk &= fieldMatches(rowNumber, "storeAddress", expectedStoreAddress,
                    storeAddress);
                rowOk &= fieldMatches(rowNumber, "storeData", expectedStoreData, storeData);
            end
            checkCount++;
            if (rowOk) begin
                $display("row %0d ok, pc %h", rowNumber, pcOut);
            end else begin
                errorCount++;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/singleCycleCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module singleCycleCpuTb import cpuPkg::*; import isaPkg::*; ();
    localparam int numRows = 23;
    localparam int clockPeriod = 100;
    localparam int resetCycles = 4;

    typedef struct packed {
        logic [wordWidth-1:0]     instr;
        logic [wordWidth-1:0]     pc;
        logic                     wbEnable;
        logic [regIndexWidth-1:0] wbRegister;
        logic [wordWidth-1:0]     wbData;
        logic                     storeEnable;
        logic [wordWidth-1:0]     storeAddress;
        logic [wordWidth-1:0]     storeData;
    } rowType;

    rowType rows [numRows];
    rowType current;
    int rowFill;

    logic clk;
    logic rstN;
    logic [wordWidth-1:0] instruction;
    logic [wordWidth-1:0] pcOut;
    logic wbEnable;
    logic [regIndexWidth-1:0] wbRegister;
    logic [wordWidth-1:0] wbData;
    logic storeEnable;
    logic [wordWidth-1:0] storeAddress;
    logic [wordWidth-1:0] storeData;
    logic checkEnable;
    int rowNumber;
    int checkCount;
    int errorCount;

    clockGen clockGen0 (
        .clk  (clk),
        .rstN (rstN)
    );

    singleCycleCpu dut0 (
        .clk          (clk),
        .rstN         (rstN),
        .instruction  (instruction),
        .pcOut        (pcOut),
        .wbEnable     (wbEnable),
        .wbRegister   (wbRegister),
        .wbData       (wbData),
        .storeEnable  (storeEnable),
        .storeAddress (storeAddress),
        .storeData    (storeData)
    );

    cpuChecker checker0 (
        .clk                  (clk),
        .checkEnable          (checkEnable),
        .rowNumber            (rowNumber),
        .expectedPc           (current.pc),
        .expectedWbEnable     (current.wbEnable),
        .expectedWbRegister   (current.wbRegister),
        .expectedWbData       (current.wbData),
        .expectedStoreEnable  (current.storeEnable),
        .expectedStoreAddress (current.storeAddress),
        .expectedStoreData    (current.storeData),
        .pcOut                (pcOut),
        .wbEnable             (wbEnable),
        .wbRegister           (wbRegister),
        .wbData               (wbData),
        .storeEnable          (storeEnable),
        .storeAddress         (storeAddress),
        .storeData            (storeData),
        .checkCount           (checkCount),
        .errorCount           (errorCount)
    );

    function automatic logic [31:0] encodeR(
        input logic [4:0] rs,
        input logic [4:0] rt,
        input logic [4:0] rd,
        input logic [4:0] shamt,
        input functType   funct
    );
        return {rType, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encodeI(
        input opcodeType   op,
        input logic [4:0]  rs,
        input logic [4:0]  rt,
        input logic [15:0] imm
    );
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(input opcodeType op, input logic [25:0] target);
        return {op, target};
    endfunction

    task automatic addRow(
        input logic [wordWidth-1:0]     instr,
        input logic [wordWidth-1:0]     pc,
        input logic                     wbEn,
        input logic [regIndexWidth-1:0] wbReg,
        input logic [wordWidth-1:0]     wbVal,
        input logic                     stEn,
        input logic [wordWidth-1:0]     stAddr,
        input logic [wordWidth-1:0]     stVal
    );
        rows[rowFill] = {instr, pc, wbEn, wbReg, wbVal, stEn, stAddr, stVal};
        rowFill++;
    endtask

    task automatic loadTable();
        // reset state, register 0 ignores writes
        addRow(encodeI(addi, 0, 0, 5), 'h00, 0, 0, 0, 0, 0, 0);
        addRow(encodeI(addi, 0, 1, 16'hfffd), 'h04, 1, 1, 'hfffffffd, 0, 0, 0);
        addRow(encodeI(addi, 0, 2, 10), 'h08, 1, 2, 'h0a, 0, 0, 0);
        addRow(encodeR(0, 2, 3, 0, add), 'h0c, 1, 3, 'h0a, 0, 0, 0);
        // r1 = -3, r2 = 10
        addRow(encodeR(1, 2, 4, 0, add), 'h10, 1, 4, 'h07, 0, 0, 0);
        addRow(encodeR(2, 1, 5, 0, sub), 'h14, 1, 5, 'h0d, 0, 0, 0);
        addRow(encodeR(1, 2, 6, 0, andOp), 'h18, 1, 6, 'h08, 0, 0, 0);
        addRow(encodeR(1, 2, 7, 0, orOp), 'h1c, 1, 7, 'hffffffff, 0, 0, 0);
        addRow(encodeR(1, 2, 8, 0, slt), 'h20, 1, 8, 'h01, 0, 0, 0);
        addRow(encodeR(2, 1, 9, 0, slt), 'h24, 1, 9, 'h00, 0, 0, 0);
        addRow(encodeR(0, 2, 10, 4, sll), 'h28, 1, 10, 'ha0, 0, 0, 0);
        // store r4 at 0x10, load it back
        addRow(encodeI(sw, 2, 4, 6), 'h2c, 0, 0, 0, 1, 'h10, 'h07);
        addRow(encodeI(lw, 0, 11, 'h10), 'h30, 1, 11, 'h07, 0, 0, 0);
        // branch outcome shows up in the next row's pc
        addRow(encodeI(beq, 3, 2, 2), 'h34, 0, 0, 0, 0, 0, 0);
        addRow(encodeI(beq, 1, 2, 5), 'h40, 0, 0, 0, 0, 0, 0);
        addRow(encodeI(bne, 1, 2, 1), 'h44, 0, 0, 0, 0, 0, 0);
        addRow(encodeI(bne, 3, 2, 7), 'h4c, 0, 0, 0, 0, 0, 0);
        addRow(encodeI(bne, 0, 1, 16'hfffa), 'h50, 0, 0, 0, 0, 0, 0);
        // jump, call, return through r31
        addRow(encodeJ(j, 'h40), 'h3c, 0, 0, 0, 0, 0, 0);
        addRow(encodeJ(jal, 'h80), 'h100, 1, 31, 'h104, 0, 0, 0);
        addRow(encodeI(addi, 31, 12, 0), 'h200, 1, 12, 'h104, 0, 0, 0);
        addRow(encodeR(31, 0, 0, 0, jr), 'h204, 0, 0, 0, 0, 0, 0);
        addRow(encodeR(5, 8, 13, 0, orOp), 'h104, 1, 13, 'h0d, 0, 0, 0);
    endtask

    initial begin
        #((resetCycles + numRows + 10) * clockPeriod);
        $display("test timed out before all table rows were applied");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        instruction = '0;
        checkEnable = 1'b0;
        rowNumber = 0;
        current = '0;
        rowFill = 0;
        loadTable();
        // reset releases on a falling edge, so the first row goes out right away
        @(posedge rstN);
        for (int r = 0; r < numRows; r++) begin
            current = rows[r];
            instruction = rows[r].instr;
            rowNumber = r;
            checkEnable = 1'b1;
            @(negedge clk);
        end
        checkEnable = 1'b0;
        instruction = '0;
        $display("rows checked %0d, failed %0d", checkCount, errorCount);
        if (errorCount == 0 && checkCount == numRows) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
